//--- src/dac_params.svh
////////////////////////////////////////////////////////////
// widths, register addresses and constant words of the
// AD5601 controller, included by the package and the RTL
////////////////////////////////////////////////////////////

`ifndef DAC_PARAMS_SVH
`define DAC_PARAMS_SVH

// bus geometry
`define DAC_DATA_W          32
`define DAC_ADDR_W          8      // byte address
`define DAC_BURST_W         4

// word addresses of the register map
`define DAC_ADDR_VERSION    0
`define DAC_ADDR_STATE      1
`define DAC_ADDR_DAC        2
`define DAC_ADDR_EN_CTRL    3
`define DAC_NUM_REGS        4

`define DAC_MODULE_ID       16'h5601
`define DAC_VERSION         16'h0001
`define DAC_DEFAULT         16'h2000   // normal mode, mid-scale code
`define DAC_SPI_BITS        16

`endif

//--- src/dac_pkg.sv
////////////////////////////////////////////////////////////
// shared bus, register access and SPI pin types
////////////////////////////////////////////////////////////

`include "dac_params.svh"

package dac_pkg;

    typedef enum logic [1:0] {
        resp_okay        = 2'b00,
        resp_slave_error = 2'b10
    } avmm_resp_e;

    typedef struct packed {
        logic                        read;
        logic                        write;
        logic [`DAC_ADDR_W-1:0]      address;     // byte address
        logic [`DAC_DATA_W-1:0]      writedata;
        logic [`DAC_DATA_W/8-1:0]    byteenable;
        logic [`DAC_BURST_W-1:0]     burstcount;
    } avmm_cmd_t;

    typedef struct packed {
        logic                        waitrequest;
        logic [`DAC_DATA_W-1:0]      readdata;
        logic                        readdatavalid;
        logic                        writeresponsevalid;
        avmm_resp_e                  response;
    } avmm_rsp_t;

    // one beat as seen by the register map
    typedef struct packed {
        logic [`DAC_ADDR_W-3:0]      word_addr;
        logic                        write;
        logic                        read;
        logic [`DAC_DATA_W-1:0]      writedata;
        logic [`DAC_DATA_W/8-1:0]    byteenable;
    } reg_access_t;

    // AD5601 input shift register layout
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [1:0] mode;     // power-down control
            logic [7:0] data;
            logic [5:0] unused;
        } fields;
    } dac_word_u;

    typedef struct packed {
        logic sclk;
        logic ss_n;
        logic sdi;
    } spi_pins_t;

endpackage

//--- src/avmm_burst_ctrl.sv
////////////////////////////////////////////////////////////
// Avalon-MM slave front end: turns single and burst
// transfers into per-beat register accesses
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "dac_params.svh"

module avmm_burst_ctrl (
    input  logic                    clk_ifc,
    input  logic                    SET_DEFAULT_ON_RESET,
    input  dac_pkg::avmm_cmd_t      avmm_cmd,
    output dac_pkg::avmm_rsp_t      avmm_rsp,
    output dac_pkg::reg_access_t    access,
    input  logic [`DAC_DATA_W-1:0]  rd_data,
    input  logic                    addr_undefined
);

    localparam int WA_W = `DAC_ADDR_W - 2;

    logic [WA_W-1:0]         cmd_word_addr;
    logic [WA_W-1:0]         cur_addr;      // next beat address within a burst
    logic [`DAC_BURST_W-1:0] beats_left;
    logic                    burst_rd;
    logic                    burst_wr;
    logic                    wr_err;        // sticky over a write burst

    assign cmd_word_addr = avmm_cmd.address[`DAC_ADDR_W-1:2];

    ////////////////////////////////////////////////////////////
    // beat decode

    always_comb begin
        access.word_addr  = (burst_rd || burst_wr) ? cur_addr : cmd_word_addr;
        access.read       = avmm_cmd.read | burst_rd;
        access.write      = avmm_cmd.write;
        access.writedata  = avmm_cmd.writedata;
        access.byteenable = avmm_cmd.byteenable;
    end

    ////////////////////////////////////////////////////////////
    // burst tracking and responses

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            avmm_rsp.waitrequest        <= 1'b1;
            avmm_rsp.readdatavalid      <= 1'b0;
            avmm_rsp.writeresponsevalid <= 1'b0;
            avmm_rsp.response           <= dac_pkg::resp_okay;
            burst_rd                    <= 1'b0;
            burst_wr                    <= 1'b0;
            wr_err                      <= 1'b0;
            cur_addr                    <= '0;
            beats_left                  <= '0;
        end else begin
            avmm_rsp.waitrequest        <= 1'b0;
            avmm_rsp.readdatavalid      <= 1'b0;
            avmm_rsp.writeresponsevalid <= 1'b0;

            if (access.read) begin
                avmm_rsp.readdatavalid <= 1'b1;
                avmm_rsp.readdata      <= rd_data;
                avmm_rsp.response      <= addr_undefined ? dac_pkg::resp_slave_error
                                                         : dac_pkg::resp_okay;
                if (burst_rd) begin
                    if (beats_left == 1) begin
                        burst_rd <= 1'b0;              // last beat
                    end else begin
                        cur_addr   <= cur_addr + 1'b1;
                        beats_left <= beats_left - 1'b1;
                    end
                end else if (avmm_cmd.burstcount > 1) begin
                    burst_rd   <= 1'b1;
                    beats_left <= avmm_cmd.burstcount - 1'b1;
                    cur_addr   <= cmd_word_addr + 1'b1;
                end
            end

            if (access.write) begin
                if (burst_wr) begin
                    if (beats_left == 1) begin
                        burst_wr                    <= 1'b0;
                        wr_err                      <= 1'b0;
                        avmm_rsp.writeresponsevalid <= 1'b1;
                        avmm_rsp.response <= (wr_err || addr_undefined)
                                             ? dac_pkg::resp_slave_error
                                             : dac_pkg::resp_okay;
                    end else begin
                        wr_err     <= wr_err | addr_undefined;
                        cur_addr   <= cur_addr + 1'b1;
                        beats_left <= beats_left - 1'b1;
                    end
                end else if (avmm_cmd.burstcount > 1) begin
                    // first beat of a write burst
                    burst_wr   <= 1'b1;
                    wr_err     <= addr_undefined;
                    beats_left <= avmm_cmd.burstcount - 1'b1;
                    cur_addr   <= cmd_word_addr + 1'b1;
                end else begin
                    avmm_rsp.writeresponsevalid <= 1'b1;
                    avmm_rsp.response <= addr_undefined ? dac_pkg::resp_slave_error
                                                        : dac_pkg::resp_okay;
                end
            end
        end
    end

endmodule

//--- src/dac_reg_map.sv
////////////////////////////////////////////////////////////
// register map: version, state, DAC register, control
// mirror; loads the DAC word from the bus or local strobe
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "dac_params.svh"

module dac_reg_map (
    input  logic                    clk_ifc,
    input  logic                    SET_DEFAULT_ON_RESET,
    input  dac_pkg::reg_access_t    access,
    output logic [`DAC_DATA_W-1:0]  rd_data,
    output logic                    addr_undefined,
    input  logic                    en_avmm_ctrl,
    input  logic [7:0]              dac_reg,
    input  logic                    dac_reg_valid_stb,
    output dac_pkg::dac_word_u      dac_word,
    output logic                    dac_written
);

    localparam int WA_W = `DAC_ADDR_W - 2;

    logic bus_dac_wr;
    logic local_dac_wr;

    // only the low two lanes hold DAC bits
    function automatic logic [15:0] merge_lanes(input logic [15:0] old_word,
                                                input logic [15:0] wdata,
                                                input logic [1:0]  be);
        logic [15:0] merged;
        merged = old_word;
        for (int i = 0; i < 2; i++) begin
            if (be[i]) begin
                merged[8*i +: 8] = wdata[8*i +: 8];
            end
        end
        return merged;
    endfunction

    assign bus_dac_wr   = access.write && en_avmm_ctrl
                          && (access.word_addr == WA_W'(`DAC_ADDR_DAC));
    assign local_dac_wr = dac_reg_valid_stb && !en_avmm_ctrl;

    assign addr_undefined = (access.word_addr >= WA_W'(`DAC_NUM_REGS));

    ////////////////////////////////////////////////////////////
    // read mux

    always_comb begin
        case (access.word_addr)
            WA_W'(`DAC_ADDR_VERSION): rd_data = {`DAC_VERSION, `DAC_MODULE_ID};
            WA_W'(`DAC_ADDR_STATE):   rd_data = 32'd1;                  // device ready
            WA_W'(`DAC_ADDR_DAC):     rd_data = {16'd0, dac_word.raw};
            WA_W'(`DAC_ADDR_EN_CTRL): rd_data = {31'd0, en_avmm_ctrl};
            default:                  rd_data = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // DAC register

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            dac_word.raw <= `DAC_DEFAULT;
            dac_written  <= 1'b0;
        end else begin
            dac_written <= bus_dac_wr | local_dac_wr;
            if (bus_dac_wr) begin
                dac_word.raw <= merge_lanes(dac_word.raw, access.writedata[15:0],
                                            access.byteenable[1:0]);
            end else if (local_dac_wr) begin
                dac_word.fields.data <= dac_reg;         // bits 13:6 only
            end
        end
    end

endmodule

//--- src/dac_spi_sequencer.sv
////////////////////////////////////////////////////////////
// starts DAC frames: default word after reset, then one
// frame per write, with writes during a frame combined
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dac_spi_sequencer (
    input  logic                  clk_ifc,
    input  logic                  SET_DEFAULT_ON_RESET,
    input  dac_pkg::dac_word_u    dac_word,
    input  logic                  dac_written,
    input  logic                  spi_done,
    output logic                  spi_start,
    output dac_pkg::dac_word_u    spi_word,
    output logic                  dac_reg_updated_stb,
    output logic                  initdone
);

    typedef enum logic [1:0] {
        st_start_rst,
        st_idle,
        st_busy
    } state_t;

    state_t state;
    logic   pending;     // write seen while a frame runs

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            state               <= st_start_rst;
            pending             <= 1'b0;
            spi_start           <= 1'b0;
            dac_reg_updated_stb <= 1'b0;
            initdone            <= 1'b0;
        end else begin
            spi_start           <= 1'b0;
            dac_reg_updated_stb <= 1'b0;

            case (state)
                st_start_rst: begin
                    spi_start <= 1'b1;                   // default word
                    spi_word  <= dac_word;
                    pending   <= dac_written;
                    state     <= st_busy;
                end

                st_idle: begin
                    if (dac_written) begin
                        spi_start <= 1'b1;
                        spi_word  <= dac_word;
                        state     <= st_busy;
                    end
                end

                st_busy: begin
                    if (dac_written) begin
                        pending <= 1'b1;
                    end
                    if (spi_done) begin
                        dac_reg_updated_stb <= 1'b1;
                        initdone            <= 1'b1;
                        if (pending || dac_written) begin
                            // follow-up frame with the latest value
                            spi_start <= 1'b1;
                            spi_word  <= dac_word;
                            pending   <= 1'b0;
                        end else begin
                            state <= st_idle;
                        end
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- src/spi_shifter.sv
////////////////////////////////////////////////////////////
// shifts one 16-bit word out to the AD5601, MSB first,
// two clocks per bit, sclk idle high
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "dac_params.svh"

module spi_shifter (
    input  logic                  clk_ifc,
    input  logic                  SET_DEFAULT_ON_RESET,
    input  logic                  start,
    input  dac_pkg::dac_word_u    word,
    output logic                  done,
    output dac_pkg::spi_pins_t    spi
);

    localparam int CNT_W = $clog2(`DAC_SPI_BITS);

    logic [`DAC_SPI_BITS-1:0] sreg;
    logic [CNT_W-1:0]         bit_cnt;
    logic                     phase;     // 0 = sclk high half, 1 = low half
    logic                     active;
    logic                     sclk;
    logic                     ss_n;

    assign spi.sclk = sclk;
    assign spi.ss_n = ss_n;
    assign spi.sdi  = sreg[`DAC_SPI_BITS-1];

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            sreg    <= '0;
            bit_cnt <= '0;
            phase   <= 1'b0;
            active  <= 1'b0;
            sclk    <= 1'b1;
            ss_n    <= 1'b1;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (!active) begin
                if (start) begin
                    active  <= 1'b1;
                    ss_n    <= 1'b0;
                    sclk    <= 1'b1;
                    sreg    <= word.raw;             // MSB on sdi right away
                    bit_cnt <= '0;
                    phase   <= 1'b0;
                end
            end else if (!phase) begin
                sclk  <= 1'b0;                       // falling edge, DAC samples
                phase <= 1'b1;
            end else begin
                sclk  <= 1'b1;                       // rising edge, next bit
                phase <= 1'b0;
                sreg  <= {sreg[`DAC_SPI_BITS-2:0], 1'b0};
                if (bit_cnt == CNT_W'(`DAC_SPI_BITS - 1)) begin
                    active <= 1'b0;
                    ss_n   <= 1'b1;
                    done   <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- src/dac_avmm_top.sv
////////////////////////////////////////////////////////////
// AD5601 controller top: bus slave, register map, frame
// sequencer and SPI shifter
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "dac_params.svh"

module dac_avmm_top (
    input  logic                  clk_ifc,
    input  logic                  SET_DEFAULT_ON_RESET,
    input  dac_pkg::avmm_cmd_t    avmm_cmd,
    output dac_pkg::avmm_rsp_t    avmm_rsp,
    input  logic                  en_avmm_ctrl,
    input  logic [7:0]            dac_reg,
    input  logic                  dac_reg_valid_stb,
    output logic                  dac_reg_updated_stb,
    output logic                  initdone,
    output dac_pkg::spi_pins_t    spi
);

    dac_pkg::reg_access_t    access;
    logic [`DAC_DATA_W-1:0]  rd_data;
    logic                    addr_undefined;
    dac_pkg::dac_word_u      dac_word;
    logic                    dac_written;
    logic                    spi_start;
    dac_pkg::dac_word_u      spi_word;
    logic                    spi_done;

    avmm_burst_ctrl u_burst (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .avmm_cmd             (avmm_cmd),
        .avmm_rsp             (avmm_rsp),
        .access               (access),
        .rd_data              (rd_data),
        .addr_undefined       (addr_undefined)
    );

    dac_reg_map u_regs (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .access               (access),
        .rd_data              (rd_data),
        .addr_undefined       (addr_undefined),
        .en_avmm_ctrl         (en_avmm_ctrl),
        .dac_reg              (dac_reg),
        .dac_reg_valid_stb    (dac_reg_valid_stb),
        .dac_word             (dac_word),
        .dac_written          (dac_written)
    );

    dac_spi_sequencer u_seq (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .dac_word             (dac_word),
        .dac_written          (dac_written),
        .spi_done             (spi_done),
        .spi_start            (spi_start),
        .spi_word             (spi_word),
        .dac_reg_updated_stb  (dac_reg_updated_stb),
        .initdone             (initdone)
    );

    spi_shifter u_spi (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .start                (spi_start),
        .word                 (spi_word),
        .done                 (spi_done),
        .spi                  (spi)
    );

endmodule

//--- dv/tb_clk_gen.sv
////////////////////////////////////////////////////////////
// testbench clock (8 ns) and 2-cycle reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_ifc,
    output logic SET_DEFAULT_ON_RESET
);

    initial begin
        clk_ifc = 1'b0;
        forever #4 clk_ifc = ~clk_ifc;
    end

    initial begin
        SET_DEFAULT_ON_RESET = 1'b1;
        repeat (2) @(posedge clk_ifc);
        #1;
        SET_DEFAULT_ON_RESET = 1'b0;    // released like any other input
    end

endmodule

//--- dv/dac_assertions.sv
////////////////////////////////////////////////////////////
// bus and SPI protocol properties, bound into the DAC top
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "dac_params.svh"

module dac_assertions (
    input logic                  clk_ifc,
    input logic                  SET_DEFAULT_ON_RESET,
    input dac_pkg::avmm_cmd_t    avmm_cmd,
    input dac_pkg::avmm_rsp_t    avmm_rsp,
    input dac_pkg::spi_pins_t    spi,
    input logic                  spi_start,
    input logic                  spi_done
);

    localparam int BC_W = `DAC_BURST_W;

    logic [BC_W-1:0] rd_owed;      // read beats still owed to the host
    logic [5:0]      frame_left;   // clocks of ss_n low left in this frame

    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            rd_owed <= '0;
        end else if (avmm_cmd.read) begin
            rd_owed <= (avmm_cmd.burstcount > 1) ? avmm_cmd.burstcount : BC_W'(1);
        end else if (avmm_rsp.readdatavalid && rd_owed != 0) begin
            rd_owed <= rd_owed - 1'b1;
        end
    end

    // a start is taken only by an idle shifter
    always_ff @(posedge clk_ifc) begin
        if (SET_DEFAULT_ON_RESET) begin
            frame_left <= '0;
        end else if (spi_start && frame_left == 0) begin
            frame_left <= 6'(2 * `DAC_SPI_BITS);
        end else if (frame_left != 0) begin
            frame_left <= frame_left - 1'b1;
        end
    end

    // ss_n low exactly for the bit clocks of a frame, high while idle
    assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        spi.ss_n == (frame_left == 0))
        else $error("ss_n low outside a frame or high inside one");

    assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        spi_done |=> !spi_done)
        else $error("shifter done pulse longer than one cycle");

    assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        avmm_rsp.readdatavalid |-> rd_owed != 0)
        else $error("readdatavalid without an outstanding read beat");

    assert property (@(posedge clk_ifc) disable iff (SET_DEFAULT_ON_RESET)
        $past(!SET_DEFAULT_ON_RESET) |-> !avmm_rsp.waitrequest)
        else $error("waitrequest high outside reset");

endmodule

bind dac_avmm_top dac_assertions u_assert (
    .clk_ifc              (clk_ifc),
    .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
    .avmm_cmd             (avmm_cmd),
    .avmm_rsp             (avmm_rsp),
    .spi                  (spi),
    .spi_start            (spi_start),
    .spi_done             (spi_done)
);

//--- dv/tb_dac.sv
////////////////////////////////////////////////////////////
// random bus and local-strobe testbench for the AD5601
// controller, with an SPI capture model and a register model
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "dac_params.svh"

module tb_dac;

    localparam int N_RD_BURST  = 8;
    localparam int N_WR        = 24;
    localparam int N_LOCAL     = 8;
    localparam int N_COMBINE   = 4;
    localparam int N_OPS       = 6 + N_RD_BURST + 4 + N_WR + 2 * N_LOCAL + 5 * N_COMBINE;
    localparam int WATCHDOG_NS = N_OPS * 64 * 8 + 2000;
    localparam int IDLE_CYCLES = 6;      // ss_n high this long means no frame due
    localparam int WAIT_LIMIT  = 200;

    logic                  clk_ifc;
    logic                  SET_DEFAULT_ON_RESET;
    dac_pkg::avmm_cmd_t    cmd;
    dac_pkg::avmm_rsp_t    rsp;
    logic                  en_avmm_ctrl;
    logic [7:0]            dac_reg;
    logic                  dac_reg_valid_stb;
    logic                  dac_reg_updated_stb;
    logic                  initdone;
    dac_pkg::spi_pins_t    spi;
    logic                  spi_sclk;
    logic                  spi_ss_n;

    integer      seed = 32'ha504_9629;
    logic [15:0] model;                  // expected DAC register
    logic [15:0] frames[$];              // words seen on the SPI pins
    logic [15:0] shift_in;
    int          bit_n;
    int          upd_cnt;
    int          n_checks;
    int          n_err;

    tb_clk_gen u_clk (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET)
    );

    dac_avmm_top dut0 (
        .clk_ifc              (clk_ifc),
        .SET_DEFAULT_ON_RESET (SET_DEFAULT_ON_RESET),
        .avmm_cmd             (cmd),
        .avmm_rsp             (rsp),
        .en_avmm_ctrl         (en_avmm_ctrl),
        .dac_reg              (dac_reg),
        .dac_reg_valid_stb    (dac_reg_valid_stb),
        .dac_reg_updated_stb  (dac_reg_updated_stb),
        .initdone             (initdone),
        .spi                  (spi)
    );

    ////////////////////////////////////////////////////////////
    // SPI capture and strobe counting

    assign spi_sclk = spi.sclk;
    assign spi_ss_n = spi.ss_n;

    always @(negedge spi_ss_n) bit_n = 0;

    always @(negedge spi_sclk) begin
        if (!spi_ss_n) begin
            shift_in = {shift_in[14:0], spi.sdi};   // DAC samples on falling sclk
            bit_n++;
            if (bit_n == 16) frames.push_back(shift_in);
        end
    end

    always @(negedge clk_ifc) begin
        if (dac_reg_updated_stb) upd_cnt++;
    end

    ////////////////////////////////////////////////////////////
    // checks and helpers

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        n_checks++;
        assert (got === exp) else begin
            $display("mismatch %s exp 0x%0h got 0x%0h", name, exp, got);
            n_err++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        n_checks++;
        assert (cond) else begin
            $display("%s", what);
            n_err++;
        end
    endtask

    task automatic tick();
        @(posedge clk_ifc);
        #1;
    endtask

    function automatic logic [15:0] lane_merge(input logic [15:0] cur,
                                               input logic [15:0] wd,
                                               input logic [1:0]  be);
        logic [15:0] mask;
        mask = {{8{be[1]}}, {8{be[0]}}};
        return (cur & ~mask) | (wd & mask);
    endfunction

    function automatic logic [31:0] exp_read(input int addr);
        case (addr)
            `DAC_ADDR_VERSION: return {`DAC_VERSION, `DAC_MODULE_ID};
            `DAC_ADDR_STATE:   return 32'h1;
            `DAC_ADDR_DAC:     return {16'h0, model};
            `DAC_ADDR_EN_CTRL: return {31'h0, en_avmm_ctrl};
            default:           return 32'h0;
        endcase
    endfunction

    function automatic dac_pkg::avmm_resp_e exp_resp(input int addr);
        if (addr >= `DAC_NUM_REGS) return dac_pkg::resp_slave_error;
        return dac_pkg::resp_okay;
    endfunction

    // read burst; beats are collected over a window fixed by the read latency
    task automatic bus_read(input int addr, input int count);
        int beats;
        beats = 0;
        cmd.read       = 1'b1;
        cmd.address    = 8'(addr * 4);
        cmd.burstcount = 4'(count);
        for (int c = 0; c < count + 3; c++) begin
            tick();
            cmd.read = 1'b0;
            if (rsp.readdatavalid) begin
                if (addr + beats < `DAC_NUM_REGS) begin
                    check_val("readdata", exp_read(addr + beats), rsp.readdata);
                end
                check_val("response", 32'(exp_resp(addr + beats)), 32'(rsp.response));
                beats++;
            end
        end
        check_val("read_beats", 32'(count), 32'(beats));
    endtask

    task automatic bus_write(input int addr, input int count, input logic gaps);
        logic [31:0] rnd;
        logic [31:0] wd;
        logic        err;
        err = 1'b0;
        for (int b = 0; b < count; b++) begin
            rnd = $random(seed);
            wd  = $random(seed);
            cmd.write      = 1'b1;
            cmd.address    = 8'((addr + b) * 4);
            cmd.writedata  = wd;
            cmd.byteenable = rnd[3:0];
            cmd.burstcount = 4'(count);
            if (addr + b == `DAC_ADDR_DAC && en_avmm_ctrl) begin
                model = lane_merge(model, wd[15:0], rnd[1:0]);
            end
            if (addr + b >= `DAC_NUM_REGS) err = 1'b1;
            tick();
            cmd.write = 1'b0;
            if (b == count - 1) begin
                check_val("writeresponsevalid", 32'h1, 32'(rsp.writeresponsevalid));
                check_val("response", err ? 32'(dac_pkg::resp_slave_error)
                                          : 32'(dac_pkg::resp_okay), 32'(rsp.response));
            end else begin
                check_val("writeresponsevalid", 32'h0, 32'(rsp.writeresponsevalid));
                if (gaps && rnd[4]) tick();             // spaced beat
            end
        end
    endtask

    task automatic wait_idle();
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < IDLE_CYCLES && waited < WAIT_LIMIT) begin
            tick();
            waited++;
            if (spi.ss_n) quiet++;
            else quiet = 0;
        end
        check_true(quiet >= IDLE_CYCLES, "SPI frames did not stop within the wait limit");
    endtask

    task automatic check_last_frame();
        check_true(frames.size() > 0, "no SPI frame captured");
        if (frames.size() > 0) begin
            check_val("spi_frame", 32'(model), 32'(frames[frames.size() - 1]));
        end
    endtask

    task automatic end_test(input int num, input string name, input int err_before);
        $display("test %0d %s finished with %0d errors", num, name, n_err - err_before);
    endtask

    ////////////////////////////////////////////////////////////
    // tests

    task automatic reset_test();
        int e0;
        int waited;
        e0 = n_err;
        @(negedge SET_DEFAULT_ON_RESET);
        tick();
        check_val("waitrequest", 32'h0, 32'(rsp.waitrequest));
        check_val("readdatavalid", 32'h0, 32'(rsp.readdatavalid));
        check_val("writeresponsevalid", 32'h0, 32'(rsp.writeresponsevalid));
        check_val("initdone", 32'h0, 32'(initdone));
        check_val("dac_reg_updated_stb", 32'h0, 32'(dac_reg_updated_stb));
        waited = 0;
        while (!initdone && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        check_true(initdone, "initdone did not rise after reset");
        wait_idle();
        check_val("frame_count", 32'h1, 32'(frames.size()));
        check_last_frame();
        check_val("updated_count", 32'h1, 32'(upd_cnt));
        bus_read(`DAC_ADDR_DAC, 1);
        end_test(1, "reset frame", e0);
    endtask

    task automatic read_test();
        int          e0;
        logic [31:0] rnd;
        e0 = n_err;
        for (int a = 0; a < `DAC_NUM_REGS; a++) bus_read(a, 1);
        for (int i = 0; i < N_RD_BURST; i++) begin
            rnd = $random(seed);
            en_avmm_ctrl = rnd[7];
            bus_read(int'(rnd[2:0]), 1 + int'(rnd[4:3]));
        end
        en_avmm_ctrl = 1'b1;
        rnd = $random(seed);
        bus_write(4 + int'(rnd[1:0]), 1, 1'b0);
        bus_write(4 + int'(rnd[3:2]), 1, 1'b0);
        bus_write(3, 2, 1'b1);                   // error only on the second beat
        bus_write(5, 3, 1'b1);
        end_test(2, "register reads", e0);
    endtask

    task automatic bus_write_test();
        int          e0;
        int          addr;
        logic [31:0] rnd;
        e0 = n_err;
        en_avmm_ctrl = 1'b1;
        for (int i = 0; i < N_WR; i++) begin
            rnd  = $random(seed);
            addr = (rnd[1:0] == 2'd3) ? `DAC_ADDR_DAC : int'(rnd[1:0]);
            bus_write(addr, 1 + int'(rnd[5:4]) % (4 - addr), rnd[8]);
            wait_idle();
            check_last_frame();
            bus_read(`DAC_ADDR_DAC, 1);
        end
        end_test(3, "bus writes", e0);
    endtask

    task automatic local_test();
        int          e0;
        int          n0;
        logic [31:0] rnd;
        e0 = n_err;
        en_avmm_ctrl = 1'b0;
        for (int i = 0; i < N_LOCAL; i++) begin
            n0 = frames.size();
            bus_write(`DAC_ADDR_DAC, 1, 1'b0);
            wait_idle();
            check_val("frame_count", 32'(n0), 32'(frames.size()));
            bus_read(`DAC_ADDR_DAC, 1);
            rnd = $random(seed);
            dac_reg           = rnd[7:0];
            dac_reg_valid_stb = 1'b1;
            model[13:6]       = rnd[7:0];
            tick();
            dac_reg_valid_stb = 1'b0;
            wait_idle();
            check_val("frame_count", 32'(n0 + 1), 32'(frames.size()));
            check_last_frame();
        end
        en_avmm_ctrl = 1'b1;
        end_test(4, "local strobe", e0);
    endtask

    task automatic combine_test();
        int          e0;
        int          n0;
        logic [31:0] rnd;
        e0 = n_err;
        for (int r = 0; r < N_COMBINE; r++) begin
            n0 = frames.size();
            for (int k = 0; k < 5; k++) begin
                bus_write(`DAC_ADDR_DAC, 1, 1'b0);
                rnd = $random(seed);
                repeat (int'(rnd[1:0]) % 3) tick();
            end
            wait_idle();
            // first write starts a frame, the rest share one follow-up
            check_val("frame_count", 32'(n0 + 2), 32'(frames.size()));
            check_last_frame();
            check_val("updated_count", 32'(frames.size()), 32'(upd_cnt));
        end
        end_test(5, "combined writes", e0);
    endtask

    initial begin
        cmd               = '0;
        en_avmm_ctrl      = 1'b1;
        dac_reg           = 8'h00;
        dac_reg_valid_stb = 1'b0;
        model             = `DAC_DEFAULT;
        shift_in          = 16'h0;
        bit_n             = 0;
        upd_cnt           = 0;
        n_checks          = 0;
        n_err             = 0;
        reset_test();
        read_test();
        bus_write_test();
        local_test();
        combine_test();
        $display("checks %0d errors %0d", n_checks, n_err);
        if (n_err == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+src
src/dac_pkg.sv
src/avmm_burst_ctrl.sv
src/dac_reg_map.sv
src/dac_spi_sequencer.sv
src/spi_shifter.sv
src/dac_avmm_top.sv
dv/tb_clk_gen.sv
dv/dac_assertions.sv
dv/tb_dac.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DAC controller testbench with Verilator
set -e

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_dac -f compile.f -o Vtb_dac
./obj_dir/Vtb_dac > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
